//--- common/arm_macros.svh
`ifndef ARM_MACROS_SVH
`define ARM_MACROS_SVH

// machine word width
`define DATA_W 32

// register index width, sixteen architectural registers
`define REG_ADDR_W 4

// entries in the instruction queue
`define QUEUE_DEPTH 4

// fetch address out of reset
`define RESET_PC 32'h0000_0000

`endif

//--- common/arm_isa_pkg.sv
`default_nettype none

package arm_isa_pkg;

	// instruction class seen by the decode stage
	// coprocessor encodings fall into cls_undef
	typedef enum logic [3:0] {
		cls_mul,
		cls_mrs,
		cls_msr,
		cls_swap,
		cls_bx,
		cls_half_reg,
		cls_half_imm,
		cls_alu,
		cls_sdt,
		cls_block,
		cls_branch,
		cls_swi,
		cls_undef
	} insn_class_t;

	// shift type, same encoding as insn[6:5]
	typedef enum logic [1:0] {
		shift_lsl = 2'b00,
		shift_lsr = 2'b01,
		shift_asr = 2'b10,
		shift_ror = 2'b11
	} shift_kind_t;

	// carry flag position in the cpsr word
	localparam int CPSR_C = 29;

endpackage

`default_nettype wire

//--- common/pipe_pkg.sv
`default_nettype none

`include "arm_macros.svh"

package pipe_pkg;

	// one queued fetch, the word plus its pipeline pc
	// pc is fetch address + 8, as r15 reads in the arm pipeline
	typedef struct packed {
		logic [`DATA_W-1:0] insn;
		logic [`DATA_W-1:0] pc;
	} queue_entry_t;

endpackage

`default_nettype wire

//--- source/fetch_seq.sv
`timescale 1ns/1ps
`default_nettype none

`include "arm_macros.svh"

module fetch_seq (
	input  wire                      clk,
	input  wire                      rst_n,
	input  wire                      insn_valid,
	input  wire [`DATA_W-1:0]        insn,
	input  wire                      pc_load,
	input  wire [`DATA_W-1:0]        pc_target,
	input  wire                      full,
	output logic                     push,
	output pipe_pkg::queue_entry_t   entry
);

	// pipeline pc runs two words ahead of the fetch address
	localparam logic [`DATA_W-1:0] pc_ahead = 8;
	localparam logic [`DATA_W-1:0] word_step = 4;

	// address of the next word to be accepted
	logic [`DATA_W-1:0] fetch_addr;

	// strobes arriving while full are dropped
	assign push = insn_valid && !full;

	// stamp with the address held before this edge
	assign entry = '{insn: insn, pc: fetch_addr + pc_ahead};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fetch_addr <= `RESET_PC;
		end else if (pc_load) begin
			// redirect beats the increment, a same-cycle push keeps the old pc
			fetch_addr <= pc_target;
		end else if (push) begin
			fetch_addr <= fetch_addr + word_step;
		end
	end

endmodule

`default_nettype wire

//--- source/insn_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "arm_macros.svh"

module insn_queue (
	input  wire                      clk,
	input  wire                      rst_n,
	input  wire                      push,
	input  wire pipe_pkg::queue_entry_t push_entry,
	input  wire                      pop,
	output pipe_pkg::queue_entry_t   head_entry,
	output logic                     full,
	output logic                     empty
);

	localparam int depth = `QUEUE_DEPTH;
	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_w = $clog2(depth + 1);

	pipe_pkg::queue_entry_t mem [depth];

	logic [ptr_w-1:0] rd_ptr;
	logic [ptr_w-1:0] wr_ptr;
	logic [cnt_w-1:0] count;
	logic [cnt_w-1:0] count_next;
	logic             do_push;
	logic             do_pop;

	// wrap at depth, depth need not be a power of two
	function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
		return (p == ptr_w'(depth - 1)) ? '0 : p + 1'b1;
	endfunction

	// guard against overflow and underflow even though neighbours obey the levels
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	always_comb begin
		count_next = count;
		if (do_push && !do_pop) begin
			count_next = count + 1'b1;
		end else if (do_pop && !do_push) begin
			count_next = count - 1'b1;
		end
	end

	// head is meaningful only while empty is low
	assign head_entry = mem[rd_ptr];

	// storage array
	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_entry;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
			full <= 1'b0;
			empty <= 1'b1;
		end else begin
			if (do_push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			count <= count_next;
			// levels registered from the next occupancy
			full <= (count_next == cnt_w'(depth));
			empty <= (count_next == '0);
		end
	end

endmodule

`default_nettype wire

//--- source/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "arm_macros.svh"

module reg_file (
	input  wire                      clk,
	input  wire                      rst_n,
	input  wire                      wr_en,
	input  wire [`REG_ADDR_W-1:0]    wr_addr,
	input  wire [`DATA_W-1:0]        wr_data,
	input  wire [`REG_ADDR_W-1:0]    read_0,
	input  wire [`REG_ADDR_W-1:0]    read_1,
	input  wire [`REG_ADDR_W-1:0]    read_2,
	output logic [`DATA_W-1:0]       rdata_0,
	output logic [`DATA_W-1:0]       rdata_1,
	output logic [`DATA_W-1:0]       rdata_2
);

	localparam int num_regs = 1 << `REG_ADDR_W;

	logic [`DATA_W-1:0] regs [num_regs];

	// single write port, whole file cleared at reset
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < num_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// async reads, a same-cycle write shows up only after the edge
	assign rdata_0 = regs[read_0];
	assign rdata_1 = regs[read_1];
	assign rdata_2 = regs[read_2];

endmodule

`default_nettype wire

//--- decode/arm_shifter.sv
`timescale 1ns/1ps
`default_nettype none

`include "arm_macros.svh"

module arm_shifter (
	input  wire [`DATA_W-1:0]  insn,
	input  wire [`DATA_W-1:0]  operand,
	input  wire [`DATA_W-1:0]  reg_amt,
	input  wire                carry_in,
	output logic [`DATA_W-1:0] result,
	output logic               carry_out
);

	arm_isa_pkg::shift_kind_t kind;
	// effective amount, up to 255 for the register form
	logic [7:0] amt;
	logic [4:0] lo;
	logic       rrx;

	assign kind = arm_isa_pkg::shift_kind_t'(insn[6:5]);
	assign lo = amt[4:0];

	always_comb begin
		rrx = 1'b0;
		if (insn[4]) begin
			// register form, bottom byte of rs
			amt = reg_amt[7:0];
		end else if (insn[11:7] == 5'd0 &&
			(kind == arm_isa_pkg::shift_lsr || kind == arm_isa_pkg::shift_asr)) begin
			// lsr #0 and asr #0 encode a shift by 32
			amt = 8'd32;
		end else begin
			amt = {3'd0, insn[11:7]};
			// ror #0 encodes rrx
			rrx = (insn[11:7] == 5'd0) && (kind == arm_isa_pkg::shift_ror);
		end
	end

	always_comb begin
		// amount zero passes through with carry unchanged
		result = operand;
		carry_out = carry_in;
		if (rrx) begin
			result = {carry_in, operand[`DATA_W-1:1]};
			carry_out = operand[0];
		end else if (amt != 8'd0) begin
			unique case (kind)
				arm_isa_pkg::shift_lsl: begin
					if (amt < 8'd32) begin
						result = operand << lo;
						// last bit shifted out is operand[32 - amt]
						carry_out = operand[5'd0 - lo];
					end else begin
						result = '0;
						carry_out = (amt == 8'd32) ? operand[0] : 1'b0;
					end
				end
				arm_isa_pkg::shift_lsr: begin
					if (amt < 8'd32) begin
						result = operand >> lo;
						carry_out = operand[lo - 5'd1];
					end else begin
						result = '0;
						carry_out = (amt == 8'd32) ? operand[`DATA_W-1] : 1'b0;
					end
				end
				arm_isa_pkg::shift_asr: begin
					if (amt < 8'd32) begin
						result = $signed(operand) >>> lo;
						carry_out = operand[lo - 5'd1];
					end else begin
						// saturates to all sign bits
						result = {`DATA_W{operand[`DATA_W-1]}};
						carry_out = operand[`DATA_W-1];
					end
				end
				arm_isa_pkg::shift_ror: begin
					if (lo == 5'd0) begin
						// multiple of 32, value unchanged, carry from bit 31
						result = operand;
						carry_out = operand[`DATA_W-1];
					end else begin
						result = (operand >> lo) | (operand << (6'd32 - {1'b0, lo}));
						carry_out = operand[lo - 5'd1];
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- decode/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "arm_macros.svh"

module decode_stage (
	input  wire                             clk,
	input  wire                             rst_n,
	input  wire                             empty,
	input  wire pipe_pkg::queue_entry_t     head_entry,
	input  wire                             stall,
	input  wire [`DATA_W-1:0]               cpsr,
	input  wire [`DATA_W-1:0]               rdata_0,
	input  wire [`DATA_W-1:0]               rdata_1,
	input  wire [`DATA_W-1:0]               rdata_2,
	output logic                            pop,
	output logic [`REG_ADDR_W-1:0]          read_0,
	output logic [`REG_ADDR_W-1:0]          read_1,
	output logic [`REG_ADDR_W-1:0]          read_2,
	output logic [`DATA_W-1:0]              op0,
	output logic [`DATA_W-1:0]              op1,
	output logic [`DATA_W-1:0]              op2,
	output logic                            carry,
	output arm_isa_pkg::insn_class_t        insn_class,
	output logic                            out_valid
);

	localparam logic [`REG_ADDR_W-1:0] pc_idx = '1;
	localparam logic [`DATA_W-1:0] pc_back = 8;
	localparam logic [`DATA_W-1:0] pc_back_reg_shift = 12;

	logic [`DATA_W-1:0]       insn;
	arm_isa_pkg::insn_class_t cls_d;
	logic                     reg_shift_alu;
	logic [`DATA_W-1:0]       pc_view;
	logic [`DATA_W-1:0]       regs0;
	logic [`DATA_W-1:0]       regs1;
	logic [`DATA_W-1:0]       shift_res;
	logic                     shift_carry;
	logic [`DATA_W-1:0]       op0_d;
	logic [`DATA_W-1:0]       op1_d;
	logic [`DATA_W-1:0]       op2_d;
	logic                     carry_d;

	// 8-bit immediate rotated right by twice the 4-bit field
	function automatic logic [`DATA_W-1:0] rot_imm(input logic [11:0] field);
		logic [`DATA_W-1:0] imm;
		logic [4:0]         rot;
		imm = {{(`DATA_W-8){1'b0}}, field[7:0]};
		rot = {field[11:8], 1'b0};
		return (imm >> rot) | (imm << (6'd32 - {1'b0, rot}));
	endfunction

	assign insn = head_entry.insn;

	// consume whenever a word waits and nothing holds us
	assign pop = !empty && !stall;

	// priority match, specific 00x encodings ahead of the alu catch-all
	always_comb begin
		casez (insn)
			32'b????000000??????????????1001????: cls_d = arm_isa_pkg::cls_mul;
			32'b????00010?001111????000000000000: cls_d = arm_isa_pkg::cls_mrs;
			32'b????00010?101001111100000000????: cls_d = arm_isa_pkg::cls_msr;
			// msr flag form, register or immediate
			32'b????00?10?1010001111????????????: cls_d = arm_isa_pkg::cls_msr;
			32'b????00010?00????????00001001????: cls_d = arm_isa_pkg::cls_swap;
			32'b????000100101111111111110001????: cls_d = arm_isa_pkg::cls_bx;
			32'b????000??0??????????00001??1????: cls_d = arm_isa_pkg::cls_half_reg;
			32'b????000??1??????????????1??1????: cls_d = arm_isa_pkg::cls_half_imm;
			// register-offset transfer with bit 4 set
			32'b????011????????????????????1????: cls_d = arm_isa_pkg::cls_undef;
			32'b????01??????????????????????????: cls_d = arm_isa_pkg::cls_sdt;
			32'b????100?????????????????????????: cls_d = arm_isa_pkg::cls_block;
			32'b????101?????????????????????????: cls_d = arm_isa_pkg::cls_branch;
			32'b????1111????????????????????????: cls_d = arm_isa_pkg::cls_swi;
			32'b????00??????????????????????????: cls_d = arm_isa_pkg::cls_alu;
			// coprocessor space lands here
			default: cls_d = arm_isa_pkg::cls_undef;
		endcase
	end

	// r15 reads as pc - 12 when the alu shifts by a register
	assign reg_shift_alu = (cls_d == arm_isa_pkg::cls_alu) && !insn[25] && insn[4];
	assign pc_view = head_entry.pc - (reg_shift_alu ? pc_back_reg_shift : pc_back);

	// register indices per class, unused ports read r0
	always_comb begin
		read_0 = '0;
		read_1 = '0;
		read_2 = '0;
		case (cls_d)
			arm_isa_pkg::cls_mul: begin
				// accumulate reg sits in 15:12
				read_0 = insn[15:12];
				read_1 = insn[3:0];
				read_2 = insn[11:8];
			end
			arm_isa_pkg::cls_msr, arm_isa_pkg::cls_bx: begin
				read_0 = insn[3:0];
			end
			arm_isa_pkg::cls_alu, arm_isa_pkg::cls_sdt: begin
				read_0 = insn[19:16];
				read_1 = insn[3:0];
				// rs for register shifts
				read_2 = insn[11:8];
			end
			arm_isa_pkg::cls_swap, arm_isa_pkg::cls_half_reg: begin
				read_0 = insn[19:16];
				read_1 = insn[3:0];
			end
			arm_isa_pkg::cls_half_imm, arm_isa_pkg::cls_block: begin
				read_0 = insn[19:16];
			end
			default: begin
			end
		endcase
	end

	// port 2 is never r15, ports 0 and 1 see the pc view
	assign regs0 = (read_0 == pc_idx) ? pc_view : rdata_0;
	assign regs1 = (read_1 == pc_idx) ? pc_view : rdata_1;

	arm_shifter shifter_i (
		.insn      (insn),
		.operand   (regs1),
		.reg_amt   (rdata_2),
		.carry_in  (cpsr[arm_isa_pkg::CPSR_C]),
		.result    (shift_res),
		.carry_out (shift_carry)
	);

	// operand forming, anything not listed stays zero
	always_comb begin
		op0_d = '0;
		op1_d = '0;
		op2_d = '0;
		carry_d = 1'b0;
		case (cls_d)
			arm_isa_pkg::cls_mul: begin
				op0_d = regs0;
				op1_d = regs1;
				op2_d = rdata_2;
			end
			arm_isa_pkg::cls_msr: begin
				// bit 25 only set in the flag form with a constant
				op0_d = insn[25] ? rot_imm(insn[11:0]) : regs0;
			end
			arm_isa_pkg::cls_swap, arm_isa_pkg::cls_half_reg: begin
				op0_d = regs0;
				op1_d = regs1;
			end
			arm_isa_pkg::cls_bx: begin
				op0_d = regs0;
			end
			arm_isa_pkg::cls_half_imm: begin
				// split offset, high nibble in 11:8
				op0_d = regs0;
				op1_d = {{(`DATA_W-8){1'b0}}, insn[11:8], insn[3:0]};
			end
			arm_isa_pkg::cls_alu: begin
				op0_d = regs0;
				if (insn[25]) begin
					op1_d = rot_imm(insn[11:0]);
					carry_d = cpsr[arm_isa_pkg::CPSR_C];
				end else begin
					op1_d = shift_res;
					carry_d = shift_carry;
				end
			end
			arm_isa_pkg::cls_sdt: begin
				op0_d = regs0;
				// in transfers a clear bit 25 means the 12-bit immediate
				if (!insn[25]) begin
					op1_d = {{(`DATA_W-12){1'b0}}, insn[11:0]};
					carry_d = cpsr[arm_isa_pkg::CPSR_C];
				end else begin
					op1_d = shift_res;
					carry_d = shift_carry;
				end
			end
			arm_isa_pkg::cls_block: begin
				// register list
				op0_d = regs0;
				op1_d = {{(`DATA_W-16){1'b0}}, insn[15:0]};
			end
			arm_isa_pkg::cls_branch: begin
				// word offset, sign extended
				op0_d = {{(`DATA_W-26){insn[23]}}, insn[23:0], 2'b00};
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else begin
			// one pulse per popped word
			out_valid <= pop;
		end
	end

	// operands hold between pops, so a stall keeps the last set
	always_ff @(posedge clk) begin
		if (pop) begin
			op0 <= op0_d;
			op1 <= op1_d;
			op2 <= op2_d;
			carry <= carry_d;
			insn_class <= cls_d;
		end
	end

endmodule

`default_nettype wire

//--- source/front_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "arm_macros.svh"

module front_top (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire                       insn_valid,
	input  wire [`DATA_W-1:0]         insn,
	input  wire                       pc_load,
	input  wire [`DATA_W-1:0]         pc_target,
	input  wire                       stall,
	input  wire [`DATA_W-1:0]         cpsr,
	input  wire                       wr_en,
	input  wire [`REG_ADDR_W-1:0]     wr_addr,
	input  wire [`DATA_W-1:0]         wr_data,
	output logic                      full,
	output logic                      out_valid,
	output logic [`DATA_W-1:0]        op0,
	output logic [`DATA_W-1:0]        op1,
	output logic [`DATA_W-1:0]        op2,
	output logic                      carry,
	output arm_isa_pkg::insn_class_t  insn_class
);

	// fetch to queue
	logic                   push;
	pipe_pkg::queue_entry_t push_entry;

	// queue to decode
	logic                   pop;
	logic                   empty;
	pipe_pkg::queue_entry_t head_entry;

	// decode to register file
	logic [`REG_ADDR_W-1:0] read_0;
	logic [`REG_ADDR_W-1:0] read_1;
	logic [`REG_ADDR_W-1:0] read_2;
	logic [`DATA_W-1:0]     rdata_0;
	logic [`DATA_W-1:0]     rdata_1;
	logic [`DATA_W-1:0]     rdata_2;

	fetch_seq fetch_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.insn_valid (insn_valid),
		.insn       (insn),
		.pc_load    (pc_load),
		.pc_target  (pc_target),
		.full       (full),
		.push       (push),
		.entry      (push_entry)
	);

	insn_queue queue_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.push       (push),
		.push_entry (push_entry),
		.pop        (pop),
		.head_entry (head_entry),
		.full       (full),
		.empty      (empty)
	);

	reg_file regs_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.read_0  (read_0),
		.read_1  (read_1),
		.read_2  (read_2),
		.rdata_0 (rdata_0),
		.rdata_1 (rdata_1),
		.rdata_2 (rdata_2)
	);

	decode_stage decode_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.empty      (empty),
		.head_entry (head_entry),
		.stall      (stall),
		.cpsr       (cpsr),
		.rdata_0    (rdata_0),
		.rdata_1    (rdata_1),
		.rdata_2    (rdata_2),
		.pop        (pop),
		.read_0     (read_0),
		.read_1     (read_1),
		.read_2     (read_2),
		.op0        (op0),
		.op1        (op1),
		.op2        (op2),
		.carry      (carry),
		.insn_class (insn_class),
		.out_valid  (out_valid)
	);

endmodule

`default_nettype wire

//--- tests/front_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "arm_macros.svh"

module front_tb;

	localparam int max_wait = 20;
	localparam logic [31:0] redirect_pc = 32'h0000_2000;

	// one table row, word plus cpsr carry in and expected decode
	typedef struct packed {
		logic [31:0]              insn;
		logic                     c_in;
		logic [31:0]              op0;
		logic [31:0]              op1;
		logic [31:0]              op2;
		logic                     carry;
		arm_isa_pkg::insn_class_t cls;
	} row_t;

	logic                     clk;
	logic                     rst_n;
	logic                     insn_valid;
	logic [`DATA_W-1:0]       insn;
	logic                     pc_load;
	logic [`DATA_W-1:0]       pc_target;
	logic                     stall;
	logic [`DATA_W-1:0]       cpsr;
	logic                     wr_en;
	logic [`REG_ADDR_W-1:0]   wr_addr;
	logic [`DATA_W-1:0]       wr_data;
	logic                     full;
	logic                     out_valid;
	logic [`DATA_W-1:0]       op0;
	logic [`DATA_W-1:0]       op1;
	logic [`DATA_W-1:0]       op2;
	logic                     carry;
	arm_isa_pkg::insn_class_t insn_class;

	integer      seed;
	logic [31:0] reg_val [16];
	row_t        rows [$];
	// fetch address model, base from reset or last redirect
	logic [31:0] fetch_base;
	int          accepted;

	front_top dut_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.insn_valid (insn_valid),
		.insn       (insn),
		.pc_load    (pc_load),
		.pc_target  (pc_target),
		.stall      (stall),
		.cpsr       (cpsr),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.full       (full),
		.out_valid  (out_valid),
		.op0        (op0),
		.op1        (op1),
		.op2        (op2),
		.carry      (carry),
		.insn_class (insn_class)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "testbench stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			fail_run($sformatf("Mismatch at %0t ns: %s expected %h actual %h",
				$time, name, expected, actual));
		end
	endtask

	// r15 as the pipeline sees it, fetch address plus 8
	function automatic logic [31:0] next_pc();
		return fetch_base + 32'(4 * accepted) + 32'd8;
	endfunction

	// pc of the word that the next table row will become
	function automatic logic [31:0] row_pc();
		return next_pc() + 32'(4 * rows.size());
	endfunction

	task automatic add_row(input logic [31:0] w, input logic c, input logic [31:0] e0,
		input logic [31:0] e1, input logic [31:0] e2, input logic ec,
		input arm_isa_pkg::insn_class_t cls);
		rows.push_back(row_t'{w, c, e0, e1, e2, ec, cls});
	endtask

	task automatic preload_regs();
		for (int i = 0; i < 16; i++) begin
			wr_en = 1'b1;
			wr_addr = 4'(i);
			wr_data = reg_val[i];
			@(negedge clk);
		end
		wr_en = 1'b0;
	endtask

	task automatic build_table();
		// alu, rotated immediate 0xff ror 8
		add_row(32'hE28214FF, 1'b1, reg_val[2], 32'hFF00_0000, 0, 1'b1,
			arm_isa_pkg::cls_alu);
		add_row(32'hE28F1005, 1'b0, row_pc() - 8, 32'd5, 0, 1'b0, arm_isa_pkg::cls_alu);
		// shifter carries come in opposite to the cpsr carry
		// lsl #4, carry is the last bit out
		add_row(32'hE0821203, !reg_val[3][28], reg_val[2], reg_val[3] << 4, 0,
			reg_val[3][28], arm_isa_pkg::cls_alu);
		// lsr #0 means lsr #32
		add_row(32'hE0821024, !reg_val[4][31], reg_val[2], 32'd0, 0, reg_val[4][31],
			arm_isa_pkg::cls_alu);
		add_row(32'hE08211C4, !reg_val[4][2], reg_val[2], 32'($signed(reg_val[4]) >>> 3), 0,
			reg_val[4][2], arm_isa_pkg::cls_alu);
		// ror #0 is rrx, carry in enters at the top
		add_row(32'hE0821063, !reg_val[3][0], reg_val[2],
			{!reg_val[3][0], reg_val[3][31:1]}, 0, reg_val[3][0], arm_isa_pkg::cls_alu);
		// shift by r5, which holds 8
		add_row(32'hE0821513, !reg_val[3][24], reg_val[2], reg_val[3] << 8, 0,
			reg_val[3][24], arm_isa_pkg::cls_alu);
		add_row(32'hE08F1536, 1'b0, row_pc() - 12, reg_val[6] >> 8, 0, reg_val[6][7],
			arm_isa_pkg::cls_alu);
		add_row(32'hE59F1010, 1'b1, row_pc() - 8, 32'h10, 0, 1'b1, arm_isa_pkg::cls_sdt);
		add_row(32'hE0278291, 1'b1, reg_val[8], reg_val[1], reg_val[2], 1'b0,
			arm_isa_pkg::cls_mul);
		add_row(32'hE1091092, 1'b0, reg_val[9], reg_val[2], 0, 1'b0, arm_isa_pkg::cls_swap);
		add_row(32'hE12FFF14, 1'b0, reg_val[4], 0, 0, 1'b0, arm_isa_pkg::cls_bx);
		add_row(32'hE129F00A, 1'b0, reg_val[10], 0, 0, 1'b0, arm_isa_pkg::cls_msr);
		// msr flags from 0xf0 ror 8
		add_row(32'hE328F4F0, 1'b1, 32'hF000_0000, 0, 0, 1'b0, arm_isa_pkg::cls_msr);
		add_row(32'hE19B10B2, 1'b0, reg_val[11], reg_val[2], 0, 1'b0,
			arm_isa_pkg::cls_half_reg);
		add_row(32'hE1DC15BA, 1'b0, reg_val[12], 32'h5A, 0, 1'b0, arm_isa_pkg::cls_half_imm);
		add_row(32'hE8BD0013, 1'b0, reg_val[13], 32'h13, 0, 1'b0, arm_isa_pkg::cls_block);
		// negative and positive branch offsets
		add_row(32'hEAFFFFFE, 1'b0, 32'hFFFF_FFF8, 0, 0, 1'b0, arm_isa_pkg::cls_branch);
		add_row(32'hEB123456, 1'b0, 32'h0048_D158, 0, 0, 1'b0, arm_isa_pkg::cls_branch);
		add_row(32'hEF000042, 1'b1, 0, 0, 0, 1'b0, arm_isa_pkg::cls_swi);
		add_row(32'hE10F1000, 1'b1, 0, 0, 0, 1'b0, arm_isa_pkg::cls_mrs);
		// coprocessor word, then register offset load with bit 4 set
		add_row(32'hEE012345, 1'b1, 0, 0, 0, 1'b0, arm_isa_pkg::cls_undef);
		add_row(32'hE7921013, 1'b1, 0, 0, 0, 1'b0, arm_isa_pkg::cls_undef);
	endtask

	task automatic send_word(input logic [31:0] w);
		insn_valid = 1'b1;
		insn = w;
		@(negedge clk);
		insn_valid = 1'b0;
		accepted++;
	endtask

	// counts rising edges from the strobe, sampling edge included
	task automatic wait_for_output(output int edges);
		int n;
		n = 1;
		while (!out_valid) begin
			if (n >= max_wait) begin
				fail_run($sformatf("timeout, out_valid stayed low for %0d cycles", max_wait));
			end
			@(negedge clk);
			n++;
		end
		edges = n;
	endtask

	task automatic run_row(input row_t r);
		int edges;
		cpsr[arm_isa_pkg::CPSR_C] = r.c_in;
		send_word(r.insn);
		wait_for_output(edges);
		check_value("latency", 32'(edges), 32'd2);
		check_value("op0", op0, r.op0);
		check_value("op1", op1, r.op1);
		check_value("op2", op2, r.op2);
		check_value("carry", {31'd0, carry}, {31'd0, r.carry});
		check_value("insn_class", 32'(insn_class), 32'(r.cls));
	endtask

	initial begin
		logic [31:0] pend_pc [`QUEUE_DEPTH];
		int          edges;
		rst_n = 1'b0;
		insn_valid = 1'b0;
		insn = '0;
		pc_load = 1'b0;
		pc_target = '0;
		stall = 1'b0;
		cpsr = '0;
		wr_en = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		seed = 5;
		for (int i = 0; i < 16; i++) begin
			reg_val[i] = 32'h1000_0001 * i;
		end
		reg_val[3] = $random(seed);
		reg_val[4] = $random(seed);
		// r5 serves as a shift amount, r6 has bit 7 set for a carry
		reg_val[5] = 32'd8;
		reg_val[6] = 32'h8000_0181;
		fetch_base = `RESET_PC;
		accepted = 0;

		repeat (5) @(negedge clk);
		rst_n = 1'b1;
		preload_regs();
		build_table();
		foreach (rows[i]) begin
			run_row(rows[i]);
		end

		// hold decode and fill the queue
		stall = 1'b1;
		for (int i = 0; i < `QUEUE_DEPTH; i++) begin
			pend_pc[i] = next_pc();
			send_word(32'hE28F_1000 | 32'(i + 1));
			check_value("out_valid", {31'd0, out_valid}, 32'd0);
		end
		check_value("full", {31'd0, full}, 32'd1);
		repeat (2) begin
			@(negedge clk);
			check_value("out_valid", {31'd0, out_valid}, 32'd0);
			check_value("full", {31'd0, full}, 32'd1);
		end
		stall = 1'b0;
		// drain in order, each word with its own pc view
		for (int i = 0; i < `QUEUE_DEPTH; i++) begin
			wait_for_output(edges);
			check_value("op0", op0, pend_pc[i] - 8);
			check_value("op1", op1, 32'(i + 1));
			@(negedge clk);
		end
		check_value("full", {31'd0, full}, 32'd0);

		// redirect, r15 then counts from the new target
		pc_load = 1'b1;
		pc_target = redirect_pc;
		@(negedge clk);
		pc_load = 1'b0;
		fetch_base = redirect_pc;
		accepted = 0;
		run_row(row_t'{32'hE28F1007, 1'b0, next_pc() - 8, 32'd7, 32'd0, 1'b0,
			arm_isa_pkg::cls_alu});
		run_row(row_t'{32'hE08F1536, 1'b0, next_pc() - 12, reg_val[6] >> 8, 32'd0,
			reg_val[6][7], arm_isa_pkg::cls_alu});

		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
+incdir+common
common/arm_isa_pkg.sv
common/pipe_pkg.sv
source/fetch_seq.sv
source/insn_queue.sv
source/reg_file.sv
decode/arm_shifter.sv
decode/decode_stage.sv
source/front_top.sv
tests/front_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the front-end testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f all.f --top-module front_tb -o front_sim

# the simulation output is shown and searched for the pass line
if ./obj_dir/front_sim | tee /dev/stderr | grep "^RESULT: PASS$" > /dev/null; then
	echo "simulation finished cleanly"
else
	echo "simulation did not pass"
	exit 1
fi
